//--- logic/pipePkg.sv
package pipePkg;

	localparam int dataW = 32;

	// one word wide so the op field lines up with the data path
	typedef enum logic [dataW-1:0] {
		ADD,
		SUB,
		AND,
		OR,
		SLT,
		SLL,
		ADDI,
		LUI,
		LW,
		SW,
		JAL
	} opCode;

	typedef enum logic [1:0] {
		RT,
		RD,
		LINK // register 31
	} dstSel;

	// operand source, youngest writer first after the register file
	typedef enum logic [2:0] {
		REG,
		EX,
		MEM1,
		MEM2,
		WB
	} fwdSel;

	typedef struct packed {
		opCode op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [dataW-1:0] imm; // already sign or zero extended by decode
		logic [4:0] shamt;
		logic [dataW-1:0] pc;
	} microOp;

endpackage

//--- logic/stageIf.sv
`timescale 1ns/1ps

interface stageIf import pipePkg::*; ();

	logic valid;
	logic wrEn; // the op in this stage writes a register
	logic isLoad;
	logic [4:0] dstAddr;
	logic [dataW-1:0] result;

	modport producer (
		output valid,
		output wrEn,
		output isLoad,
		output dstAddr,
		output result
	);

	modport consumer (
		input valid,
		input wrEn,
		input isLoad,
		input dstAddr,
		input result
	);

endinterface

//--- logic/regFile.sv
`timescale 1ns/1ps

module regFile import pipePkg::*; (
	input  logic clk,
	input  logic rstN,
	input  logic [4:0] rdAddrA,
	input  logic [4:0] rdAddrB,
	output logic [dataW-1:0] rdDataA,
	output logic [dataW-1:0] rdDataB,
	input  logic wrEn,
	input  logic [4:0] wrAddr,
	input  logic [dataW-1:0] wrData
);

	logic [dataW-1:0] regs [32];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && wrAddr != 5'd0) begin
			regs[wrAddr] <= wrData;
		end
	end

	// a write in the same cycle is passed straight through to the reader
	assign rdDataA = (rdAddrA == 5'd0) ? '0 :
		(wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
	assign rdDataB = (rdAddrB == 5'd0) ? '0 :
		(wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

//--- logic/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit import pipePkg::*; (
	input  logic [4:0] rs,
	input  logic [4:0] rt,
	input  logic usesRt,
	stageIf.consumer ex,
	stageIf.consumer mem1,
	stageIf.consumer mem2,
	stageIf.consumer wb,
	output fwdSel fwdA,
	output fwdSel fwdB,
	output logic stall
);

	logic [3:0] hitA; // bit 0 is EX, bit 3 is WB
	logic [3:0] hitB;
	logic loadA;
	logic loadB;

	function automatic logic hits(input logic valid, input logic wrEn,
		input logic [4:0] dst, input logic [4:0] src);
		return valid && wrEn && dst != 5'd0 && dst == src;
	endfunction

	function automatic fwdSel pick(input logic [3:0] hit);
		if (hit[0]) return EX;
		else if (hit[1]) return MEM1;
		else if (hit[2]) return MEM2;
		else if (hit[3]) return WB;
		else return REG;
	endfunction

	assign hitA = {hits(wb.valid, wb.wrEn, wb.dstAddr, rs),
		hits(mem2.valid, mem2.wrEn, mem2.dstAddr, rs),
		hits(mem1.valid, mem1.wrEn, mem1.dstAddr, rs),
		hits(ex.valid, ex.wrEn, ex.dstAddr, rs)};
	assign hitB = {4{usesRt}} & {hits(wb.valid, wb.wrEn, wb.dstAddr, rt),
		hits(mem2.valid, mem2.wrEn, mem2.dstAddr, rt),
		hits(mem1.valid, mem1.wrEn, mem1.dstAddr, rt),
		hits(ex.valid, ex.wrEn, ex.dstAddr, rt)};

	assign fwdA = pick(hitA);
	assign fwdB = pick(hitB);

	// load data is only there once the load reaches MEM2
	assign loadA = (fwdA == EX && ex.isLoad) || (fwdA == MEM1 && mem1.isLoad);
	assign loadB = (fwdB == EX && ex.isLoad) || (fwdB == MEM1 && mem1.isLoad);
	assign stall = loadA || loadB;

endmodule

//--- logic/operandSelect.sv
`timescale 1ns/1ps

module operandSelect import pipePkg::*; (
	input  microOp issueOp,
	input  logic [dataW-1:0] rfA,
	input  logic [dataW-1:0] rfB,
	input  fwdSel fwdA,
	input  fwdSel fwdB,
	stageIf.consumer ex,
	stageIf.consumer mem1,
	stageIf.consumer mem2,
	stageIf.consumer wb,
	output logic usesRt,
	output logic [dataW-1:0] opA,
	output logic [dataW-1:0] opB,
	output logic [dataW-1:0] storeData
);

	logic [dataW-1:0] fwdValA;
	logic [dataW-1:0] fwdValB;
	logic immB;

	function automatic logic [dataW-1:0] fwdMux(input fwdSel sel,
		input logic [dataW-1:0] rf, input logic [dataW-1:0] exVal,
		input logic [dataW-1:0] m1Val, input logic [dataW-1:0] m2Val,
		input logic [dataW-1:0] wbVal);
		case (sel)
			EX: return exVal;
			MEM1: return m1Val;
			MEM2: return m2Val;
			WB: return wbVal;
			default: return rf;
		endcase
	endfunction

	assign usesRt = issueOp.op inside {ADD, SUB, AND, OR, SLT, SLL, SW}; // SW needs rt as store data
	assign immB = issueOp.op inside {ADDI, LUI, LW, SW};

	assign fwdValA = fwdMux(fwdA, rfA, ex.result, mem1.result, mem2.result, wb.result);
	assign fwdValB = fwdMux(fwdB, rfB, ex.result, mem1.result, mem2.result, wb.result);

	// shifts take the amount from the op itself, the value to shift comes in on B
	assign opA = (issueOp.op == SLL) ? {{(dataW-5){1'b0}}, issueOp.shamt} : fwdValA;
	assign opB = immB ? issueOp.imm : fwdValB;
	assign storeData = fwdValB;

endmodule

//--- logic/execStage.sv
`timescale 1ns/1ps

module execStage import pipePkg::*; (
	input  logic clk,
	input  logic rstN,
	input  logic accept,
	input  microOp issueOp,
	input  logic [dataW-1:0] opA,
	input  logic [dataW-1:0] opB,
	input  logic [dataW-1:0] storeData,
	stageIf.producer ex,
	output microOp exOp,
	output logic [dataW-1:0] exStoreData
);

	logic exValid;
	logic [dataW-1:0] aReg;
	logic [dataW-1:0] bReg;
	logic [dataW-1:0] aluOut;
	dstSel dst;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exValid <= 1'b0;
		end else begin
			exValid <= accept; // a stall leaves a bubble behind
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			exOp <= issueOp;
			aReg <= opA;
			bReg <= opB;
			exStoreData <= storeData;
		end
	end

	always_comb begin
		case (exOp.op)
			SUB: aluOut = aReg - bReg;
			AND: aluOut = aReg & bReg;
			OR: aluOut = aReg | bReg;
			SLT: aluOut = {{(dataW-1){1'b0}}, $signed(aReg) < $signed(bReg)};
			SLL: aluOut = bReg << aReg[4:0];
			default: aluOut = aReg + bReg; // also the address of LW and SW
		endcase
	end

	always_comb begin
		case (exOp.op)
			ADDI, LUI, LW, SW: dst = RT;
			JAL: dst = LINK;
			default: dst = RD;
		endcase
	end

	always_comb begin
		case (dst)
			RT: ex.dstAddr = exOp.rt;
			RD: ex.dstAddr = exOp.rd;
			default: ex.dstAddr = 5'd31;
		endcase
	end

	always_comb begin
		case (exOp.op)
			LUI: ex.result = exOp.imm << 16;
			JAL: ex.result = exOp.pc + 32'd8;
			default: ex.result = aluOut;
		endcase
	end

	assign ex.valid = exValid;
	assign ex.wrEn = (exOp.op != SW);
	assign ex.isLoad = (exOp.op == LW);

endmodule

//--- logic/memStages.sv
`timescale 1ns/1ps

module memStages import pipePkg::*; #(
	parameter int memDepth = 64
) (
	input  logic clk,
	input  logic rstN,
	input  microOp exOp,
	stageIf.consumer ex,
	input  logic [dataW-1:0] exStoreData,
	stageIf.producer mem1,
	stageIf.producer mem2
);

	localparam int idxW = $clog2(memDepth);

	logic [dataW-1:0] mem [memDepth];
	logic m1Valid, m1WrEn, m1Load;
	logic m2Valid, m2WrEn, m2Load;
	logic [4:0] m1Dst;
	logic [4:0] m2Dst;
	logic [dataW-1:0] m1Result;
	logic [dataW-1:0] m2Result;

	// word address, wrapped to the memory size
	function automatic logic [idxW-1:0] wordIdx(input logic [dataW-1:0] addr);
		return addr[idxW+1:2];
	endfunction

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			m1Valid <= 1'b0;
			m2Valid <= 1'b0;
		end else begin
			m1Valid <= ex.valid;
			m2Valid <= m1Valid;
		end
	end

	always_ff @(posedge clk) begin
		if (ex.valid && exOp.op == SW) begin
			mem[wordIdx(ex.result)] <= exStoreData;
		end
		m1WrEn <= ex.wrEn;
		m1Load <= ex.isLoad;
		m1Dst <= ex.dstAddr;
		m1Result <= ex.result;
		m2WrEn <= m1WrEn;
		m2Load <= m1Load;
		m2Dst <= m1Dst;
		m2Result <= m1Load ? mem[wordIdx(m1Result)] : m1Result; // load word replaces the address
	end

	assign mem1.valid = m1Valid;
	assign mem1.wrEn = m1WrEn;
	assign mem1.isLoad = m1Load;
	assign mem1.dstAddr = m1Dst;
	assign mem1.result = m1Result;

	assign mem2.valid = m2Valid;
	assign mem2.wrEn = m2WrEn;
	assign mem2.isLoad = m2Load;
	assign mem2.dstAddr = m2Dst;
	assign mem2.result = m2Result;

endmodule

//--- logic/pipeTop.sv
`timescale 1ns/1ps

module pipeTop import pipePkg::*; #(
	parameter int memDepth = 64
) (
	input  logic clk,
	input  logic rstN,
	input  logic issueValid,
	output logic issueReady,
	input  microOp issueOp,
	output logic wbValid,
	output logic [4:0] wbAddr,
	output logic [dataW-1:0] wbData
);

	logic [dataW-1:0] rfA, rfB;
	logic [dataW-1:0] opA, opB, storeData;
	logic [dataW-1:0] exStoreData;
	fwdSel fwdA, fwdB;
	logic stall, usesRt, accept, wbWrite;
	microOp exOp;

	stageIf exStage ();
	stageIf mem1Stage ();
	stageIf mem2Stage ();
	stageIf wbStage ();

	assign issueReady = !stall;
	assign accept = issueValid && issueReady;

	regFile i_regFile (.clk, .rstN, .rdAddrA(issueOp.rs), .rdAddrB(issueOp.rt),
		.rdDataA(rfA), .rdDataB(rfB), .wrEn(wbWrite), .wrAddr(wbStage.dstAddr),
		.wrData(wbStage.result));

	hazardUnit i_hazardUnit (.rs(issueOp.rs), .rt(issueOp.rt), .usesRt, .ex(exStage),
		.mem1(mem1Stage), .mem2(mem2Stage), .wb(wbStage), .fwdA, .fwdB, .stall);

	operandSelect i_operandSelect (.issueOp, .rfA, .rfB, .fwdA, .fwdB, .ex(exStage),
		.mem1(mem1Stage), .mem2(mem2Stage), .wb(wbStage), .usesRt, .opA, .opB, .storeData);

	execStage i_execStage (.clk, .rstN, .accept, .issueOp, .opA, .opB, .storeData,
		.ex(exStage), .exOp, .exStoreData);

	memStages #(.memDepth(memDepth)) i_memStages (.clk, .rstN, .exOp, .ex(exStage),
		.exStoreData, .mem1(mem1Stage), .mem2(mem2Stage));

	// WB register, the last pipeline stage
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wbStage.valid <= 1'b0;
		end else begin
			wbStage.valid <= mem2Stage.valid;
		end
	end

	always_ff @(posedge clk) begin
		wbStage.wrEn <= mem2Stage.wrEn;
		wbStage.isLoad <= mem2Stage.isLoad;
		wbStage.dstAddr <= mem2Stage.dstAddr;
		wbStage.result <= mem2Stage.result;
	end

	// stores and writes to register 0 never show up on the writeback port
	assign wbWrite = wbStage.valid && wbStage.wrEn && wbStage.dstAddr != 5'd0;
	assign wbValid = wbWrite;
	assign wbAddr = wbStage.dstAddr;
	assign wbData = wbStage.result;

endmodule

//--- testbench/pipeTop_asserts.sv
`timescale 1ns/1ps

module pipeTopAsserts import pipePkg::*; (
	input logic clk,
	input logic rstN,
	input logic issueValid,
	input logic issueReady,
	input microOp issueOp,
	input logic wbValid,
	input logic [4:0] wbAddr
);

	int failCount = 0;
	logic accept;
	logic [4:0] issueDst;
	logic writesReg;

	assign accept = issueValid && issueReady;

	// immediate ops and loads land in rt, JAL links into r31, the rest land in rd
	always_comb begin
		case (issueOp.op)
			ADDI, LUI, LW, SW: issueDst = issueOp.rt;
			JAL: issueDst = 5'd31;
			default: issueDst = issueOp.rd;
		endcase
	end

	assign writesReg = (issueOp.op != SW) && (issueDst != 5'd0); // stores write nothing

	resetState: assert property (@(posedge clk) !rstN |=> issueReady && !wbValid)
		else begin
			failCount++;
			$error("issueReady low or wbValid high out of reset");
		end

	wbLatency: assert property (@(posedge clk) disable iff (!rstN)
		accept && writesReg |-> ##4 wbValid)
		else begin
			failCount++;
			$error("writeback missing 4 cycles after issue");
		end

	noWbLatency: assert property (@(posedge clk) disable iff (!rstN)
		accept && !writesReg |-> ##4 !wbValid)
		else begin
			failCount++;
			$error("writeback from an op that writes no register");
		end

	// every writeback goes to its own op's destination, never r0
	wbDest: assert property (@(posedge clk) disable iff (!rstN)
		accept && writesReg |-> ##4 wbAddr == $past(issueDst, 4))
		else begin
			failCount++;
			$error("writeback address differs from the op's destination");
		end

	holdOp: assert property (@(posedge clk) disable iff (!rstN)
		issueValid && !issueReady |=> $stable(issueOp))
		else begin
			failCount++;
			$error("issueOp changed while held off");
		end

endmodule

bind pipeTop pipeTopAsserts i_asserts (.*);

//--- testbench/pipeTb.sv
`timescale 1ns/1ps

module pipeTb import pipePkg::*; ();

	localparam int memDepth = 64;
	localparam int seed = 69034;
	localparam int waitLimit = 20; // cycles
	localparam time drvDelay = 10ns;

	typedef struct packed {
		logic [4:0] addr;
		logic [dataW-1:0] data;
	} wbEntry;

	logic clk;
	logic rstN;
	logic issueValid;
	logic issueReady;
	microOp issueOp;
	logic wbValid;
	logic [4:0] wbAddr;
	logic [dataW-1:0] wbData;

	logic [dataW-1:0] modelRegs [32];
	logic [dataW-1:0] modelMem [memDepth];
	wbEntry expQ [$];
	logic [dataW-1:0] pc;
	int errCount = 0;
	bit hung = 1'b0; // set once a wait runs out, the remaining stimulus is skipped

	pipeTop #(.memDepth(memDepth)) i_pipeTop (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic microOp makeOp(input opCode code, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [dataW-1:0] imm,
		input logic [4:0] shamt);
		microOp op;
		op = '0;
		op.op = code;
		op.rs = rs;
		op.rt = rt;
		op.rd = rd;
		op.imm = imm;
		op.shamt = shamt;
		return op;
	endfunction

	task automatic endRun(input bit timedOut);
		$display("errors: %0d writeback checks, %0d bound assertions", errCount,
			i_pipeTop.i_asserts.failCount);
		if (!timedOut && errCount == 0 && i_pipeTop.i_asserts.failCount == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	endtask

	// executes one op in program order and records the register write it should make
	task automatic runModel(input microOp op);
		logic [dataW-1:0] a;
		logic [dataW-1:0] b;
		logic [dataW-1:0] val;
		logic [dataW-1:0] idx;
		logic [4:0] dst;
		a = modelRegs[op.rs];
		b = modelRegs[op.rt];
		idx = ((a + op.imm) >> 2) % memDepth; // word address wraps around the memory
		dst = op.rd;
		case (op.op)
			ADD: val = a + b;
			SUB: val = a - b;
			AND: val = a & b;
			OR: val = a | b;
			SLT: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			SLL: val = b << op.shamt;
			ADDI: val = a + op.imm;
			LUI: val = op.imm << 16;
			LW: val = modelMem[idx];
			JAL: val = op.pc + 32'd8;
			default: val = '0;
		endcase
		if (op.op == SW) begin
			modelMem[idx] = b;
			dst = 5'd0;
		end else if (op.op inside {ADDI, LUI, LW}) begin
			dst = op.rt;
		end else if (op.op == JAL) begin
			dst = 5'd31; // link register
		end
		if (dst != 5'd0) begin
			modelRegs[dst] = val;
			expQ.push_back('{addr: dst, data: val});
		end
	endtask

	task automatic issue(input microOp op, output int stalls);
		stalls = 0;
		if (hung) begin
			return;
		end
		op.pc = pc;
		pc = pc + 32'd4;
		issueOp = op;
		issueValid = 1'b1;
		@(negedge clk);
		while (!issueReady && stalls < waitLimit) begin
			stalls++;
			@(negedge clk);
		end
		if (!issueReady) begin
			$display("timeout: issueReady stayed low for %0d cycles", stalls);
			hung = 1'b1;
		end else begin
			@(posedge clk); // accepted on this edge
			#drvDelay;
			issueValid = 1'b0;
			runModel(op);
		end
	endtask

	task automatic drain();
		int cycles;
		cycles = 0;
		while (expQ.size() != 0 && cycles < waitLimit) begin
			@(posedge clk);
			cycles++;
		end
		if (expQ.size() != 0) begin
			$display("timeout: %0d expected writebacks never arrived", expQ.size());
			hung = 1'b1;
		end else begin
			repeat (6) @(posedge clk); // a stray late writeback would still show up here
		end
	endtask

	always @(negedge clk) begin : checkWb
		wbEntry want;
		if (rstN && wbValid) begin
			assert (expQ.size() != 0) else begin
				errCount++;
				$display("FAIL %0t: writeback to r%0d that no op produced", $time, wbAddr);
			end
			if (expQ.size() != 0) begin
				want = expQ.pop_front();
				assert (wbAddr == want.addr && wbData == want.data) else begin
					errCount++;
					$display("FAIL %0t: writeback r%0d=%h, expected r%0d=%h", $time,
						wbAddr, wbData, want.addr, want.data);
				end
			end
		end
	end

	initial begin
		int stalls;
		logic [dataW-1:0] addr;
		void'($urandom(seed));
		issueValid = 1'b0;
		issueOp = '0;
		rstN = 1'b0;
		pc = 32'h0000_1000;
		modelRegs = '{default: '0};
		modelMem = '{default: '0};
		addr = '0;
		repeat (2) @(posedge clk);
		#drvDelay;
		rstN = 1'b1;

		// independent ALU, immediate, LUI and SLL ops
		for (int r = 1; r <= 4; r++) begin
			issue(makeOp(ADDI, 5'd0, 5'(r), 5'd0, $urandom, 5'd0), stalls);
		end
		issue(makeOp(ADD, 5'd1, 5'd2, 5'd5, '0, 5'd0), stalls);
		issue(makeOp(SUB, 5'd3, 5'd4, 5'd6, '0, 5'd0), stalls);
		issue(makeOp(AND, 5'd1, 5'd3, 5'd7, '0, 5'd0), stalls);
		issue(makeOp(OR, 5'd2, 5'd4, 5'd8, '0, 5'd0), stalls);
		issue(makeOp(SLT, 5'd1, 5'd2, 5'd9, '0, 5'd0), stalls);
		issue(makeOp(SLL, 5'd0, 5'd3, 5'd10, '0, 5'($urandom_range(31))), stalls);
		issue(makeOp(LUI, 5'd0, 5'd11, 5'd0, $urandom, 5'd0), stalls);

		// producer and consumer at distance 1 to 5, first on rs and then on rt
		for (int d = 1; d <= 5; d++) begin
			issue(makeOp(ADDI, 5'd1, 5'd12, 5'd0, $urandom, 5'd0), stalls);
			for (int f = 1; f < d; f++) begin
				issue(makeOp(ADDI, 5'd0, 5'(20 + f), 5'd0, $urandom, 5'd0), stalls);
			end
			issue(makeOp(ADD, 5'd12, 5'd2, 5'd13, '0, 5'd0), stalls);
			issue(makeOp(ADDI, 5'd3, 5'd12, 5'd0, $urandom, 5'd0), stalls);
			for (int f = 1; f < d; f++) begin
				issue(makeOp(ADDI, 5'd0, 5'(20 + f), 5'd0, $urandom, 5'd0), stalls);
			end
			issue(makeOp(SUB, 5'd4, 5'd12, 5'd14, '0, 5'd0), stalls);
		end

		// store then load back, once directly and once through the wrapped address
		for (int k = 0; k < 4; k++) begin
			addr = $urandom & ~32'd3;
			issue(makeOp(ADDI, 5'd0, 5'd15, 5'd0, $urandom, 5'd0), stalls);
			issue(makeOp(SW, 5'd0, 5'd15, 5'd0, addr, 5'd0), stalls);
			issue(makeOp(LW, 5'd0, 5'd16, 5'd0, addr, 5'd0), stalls);
			issue(makeOp(LW, 5'd0, 5'd17, 5'd0, addr + memDepth * 4, 5'd0), stalls);
		end

		// load-use right behind the load and with one op between
		issue(makeOp(LW, 5'd0, 5'd18, 5'd0, addr, 5'd0), stalls);
		issue(makeOp(ADD, 5'd18, 5'd18, 5'd19, '0, 5'd0), stalls);
		assert (hung || stalls > 0) else begin
			errCount++;
			$display("FAIL %0t: load-use at distance 1 was not held off", $time);
		end
		issue(makeOp(LW, 5'd0, 5'd18, 5'd0, addr, 5'd0), stalls);
		issue(makeOp(ADDI, 5'd0, 5'd21, 5'd0, $urandom, 5'd0), stalls);
		issue(makeOp(SUB, 5'd1, 5'd18, 5'd19, '0, 5'd0), stalls);
		assert (hung || stalls > 0) else begin
			errCount++;
			$display("FAIL %0t: load-use at distance 2 was not held off", $time);
		end

		// JAL links into r31, writes to r0 vanish
		issue(makeOp(JAL, 5'd0, 5'd0, 5'd0, '0, 5'd0), stalls);
		issue(makeOp(ADD, 5'd31, 5'd1, 5'd22, '0, 5'd0), stalls);
		issue(makeOp(ADDI, 5'd1, 5'd0, 5'd0, $urandom, 5'd0), stalls);
		issue(makeOp(OR, 5'd1, 5'd2, 5'd0, '0, 5'd0), stalls);
		issue(makeOp(ADD, 5'd0, 5'd0, 5'd23, '0, 5'd0), stalls);

		if (!hung) begin
			drain();
		end
		endRun(hung);
	end

endmodule

//--- build.f
logic/pipePkg.sv
logic/stageIf.sv
logic/regFile.sv
logic/hazardUnit.sv
logic/operandSelect.sv
logic/execStage.sv
logic/memStages.sv
logic/pipeTop.sv
testbench/pipeTop_asserts.sv
testbench/pipeTb.sv

//--- Bender.yml
package:
  name: pipe_datapath

sources:
  - logic/pipePkg.sv
  - logic/stageIf.sv
  - logic/regFile.sv
  - logic/hazardUnit.sv
  - logic/operandSelect.sv
  - logic/execStage.sv
  - logic/memStages.sv
  - logic/pipeTop.sv
  - target: test
    files:
      - testbench/pipeTop_asserts.sv
      - testbench/pipeTb.sv
